// ==== include/bp_cfg.svh ====
`ifndef BP_CFG_SVH
`define BP_CFG_SVH

// depth of both return address stacks.
`define BP_RAS_ENTRIES 8

// virtual address width.
`define BP_VADDR_W 32

`endif

// ==== source/bp_pkg.sv ====
`default_nettype none

`include "bp_cfg.svh"

package bp_pkg;

    typedef logic [`BP_VADDR_W-1:0] virt_t;

    typedef struct packed {
        logic  valid;
        virt_t data;
    } ras_t;

    // jal immediate is scattered over the upper 20 bits.
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_insn_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_insn_t;

    typedef union packed {
        j_insn_t j;
        i_insn_t i;
    } insn_u;

    typedef enum logic [1:0] {
        kind_seq,
        kind_call,
        kind_ret,
        kind_coret
    } br_kind_e;

    typedef struct packed {
        logic     push;
        logic     pop;
        virt_t    link;
        virt_t    target;
        br_kind_e kind;
    } ras_op_t;

    typedef struct packed {
        logic     valid;
        virt_t    pc;
        br_kind_e kind;
    } pred_t;

    localparam logic [6:0] opc_jal  = 7'b1101111;
    localparam logic [6:0] opc_jalr = 7'b1100111;

endpackage

`default_nettype wire

// ==== source/ras.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bp_cfg.svh"

module ras #(
    parameter int entries_num = `BP_RAS_ENTRIES
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          flush,
    input  logic          push_req,
    input  logic          pop_req,
    input  bp_pkg::virt_t push_data,
    input  logic          commit_push_req,
    input  logic          commit_pop_req,
    input  bp_pkg::virt_t commit_push_data,
    output bp_pkg::ras_t  ras_top
);

    import bp_pkg::*;

    // entry 0 is the top of the stack.
    typedef ras_t [entries_num-1:0] stack_t;

    stack_t spec_q;
    stack_t spec_nxt;
    stack_t commit_q;
    stack_t commit_nxt;

    // next state of one stack for a single cycle of requests.
    function automatic stack_t stack_next(
        input stack_t cur,
        input logic   push,
        input logic   pop,
        input virt_t  din
    );
        stack_t nxt;
        nxt = cur;
        if (push && pop) begin
            // co-routine swap, top replaced in place.
            nxt[0].valid = 1'b1;
            nxt[0].data  = din;
        end else if (push) begin
            // oldest entry falls off the bottom when full.
            nxt[entries_num-1:1] = cur[entries_num-2:0];
            nxt[0].valid         = 1'b1;
            nxt[0].data          = din;
        end else if (pop) begin
            nxt[entries_num-2:0]     = cur[entries_num-1:1];
            nxt[entries_num-1].valid = 1'b0;
            nxt[entries_num-1].data  = '0;
        end
        return nxt;
    endfunction

    always_comb begin
        spec_nxt   = stack_next(spec_q, push_req, pop_req, push_data);
        commit_nxt = stack_next(commit_q, commit_push_req, commit_pop_req,
                                commit_push_data);
    end

    // on flush the speculative copy takes the committed copy, including
    // this cycle's retire update; the fetch update is dropped.
    always_ff @(posedge clk) begin
        if (reset) begin
            spec_q <= '0;
        end else if (flush) begin
            spec_q <= commit_nxt;
        end else begin
            spec_q <= spec_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            commit_q <= '0;
        end else begin
            commit_q <= commit_nxt;
        end
    end

    assign ras_top = spec_q[0];

endmodule

`default_nettype wire

// ==== source/ret_predecode.sv ====
`timescale 1ns/1ns
`default_nettype none

module ret_predecode (
    input  logic            valid,
    input  bp_pkg::virt_t   pc,
    input  bp_pkg::insn_u   insn,
    output bp_pkg::ras_op_t op
);

    import bp_pkg::*;

    logic              is_jal;
    logic              is_jalr;
    logic              rd_link;
    logic              rs1_link;
    logic signed [20:0] j_imm;
    virt_t             link_addr;
    virt_t             jal_target;

    // x1 and x5 are the link registers.
    function automatic logic is_link(input logic [4:0] r);
        return (r == 5'd1) || (r == 5'd5);
    endfunction

    assign is_jal  = insn.j.opcode == opc_jal;
    assign is_jalr = (insn.i.opcode == opc_jalr) && (insn.i.funct3 == 3'b000);

    // rd sits in the same bits in both views.
    assign rd_link  = is_link(insn.i.rd);
    assign rs1_link = is_link(insn.i.rs1);

    assign j_imm = {insn.j.imm20, insn.j.imm19_12, insn.j.imm11,
                    insn.j.imm10_1, 1'b0};

    assign link_addr  = pc + virt_t'(4);
    assign jal_target = pc + virt_t'(j_imm);

    always_comb begin
        op.push   = 1'b0;
        op.pop    = 1'b0;
        op.kind   = kind_seq;
        op.link   = link_addr;
        // a jalr call has no known target, so it falls through.
        op.target = is_jal ? jal_target : link_addr;

        if (valid) begin
            if (is_jal) begin
                if (rd_link) begin
                    op.push = 1'b1;
                    op.kind = kind_call;
                end
            end else if (is_jalr) begin
                if (rd_link && rs1_link) begin
                    op.push = 1'b1;
                    op.pop  = 1'b1;
                    op.kind = kind_coret;
                end else if (rd_link) begin
                    op.push = 1'b1;
                    op.kind = kind_call;
                end else if ((insn.i.rd == 5'd0) && rs1_link) begin
                    op.pop  = 1'b1;
                    op.kind = kind_ret;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/next_pc_select.sv ====
`timescale 1ns/1ns
`default_nettype none

module next_pc_select (
    input  logic            clk,
    input  logic            reset,
    input  logic            fetch_valid,
    input  logic            flush,
    input  bp_pkg::ras_op_t op,
    input  bp_pkg::ras_t    ras_top,
    output bp_pkg::pred_t   pred
);

    import bp_pkg::*;

    virt_t    next_pc;
    logic     pred_valid_q;
    virt_t    pred_pc_q;
    br_kind_e pred_kind_q;

    // ras_top is still the value before this instruction's own update.
    always_comb begin
        unique case (op.kind)
            kind_ret, kind_coret: begin
                next_pc = ras_top.valid ? ras_top.data : op.link;
            end
            kind_call: begin
                next_pc = op.target;
            end
            default: begin
                next_pc = op.link;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pred_valid_q <= 1'b0;
        end else begin
            pred_valid_q <= fetch_valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        pred_pc_q   <= next_pc;
        pred_kind_q <= op.kind;
    end

    assign pred.valid = pred_valid_q;
    assign pred.pc    = pred_pc_q;
    assign pred.kind  = pred_kind_q;

endmodule

`default_nettype wire

// ==== source/bp_ras_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module bp_ras_top (
    input  logic          clk,
    input  logic          reset,
    input  logic          fetch_valid,
    input  bp_pkg::virt_t fetch_pc,
    input  bp_pkg::insn_u fetch_insn,
    input  logic          retire_valid,
    input  bp_pkg::virt_t retire_pc,
    input  bp_pkg::insn_u retire_insn,
    input  logic          flush,
    output bp_pkg::pred_t pred
);

    import bp_pkg::*;

    ras_op_t fetch_op;
    ras_op_t retire_op;
    ras_t    ras_top;

    ret_predecode u_fetch_dec (
        .valid (fetch_valid),
        .pc    (fetch_pc),
        .insn  (fetch_insn),
        .op    (fetch_op)
    );

    ret_predecode u_retire_dec (
        .valid (retire_valid),
        .pc    (retire_pc),
        .insn  (retire_insn),
        .op    (retire_op)
    );

    ras u_ras (
        .clk              (clk),
        .reset            (reset),
        .flush            (flush),
        .push_req         (fetch_op.push),
        .pop_req          (fetch_op.pop),
        .push_data        (fetch_op.link),
        .commit_push_req  (retire_op.push),
        .commit_pop_req   (retire_op.pop),
        .commit_push_data (retire_op.link),
        .ras_top          (ras_top)
    );

    next_pc_select u_next_pc (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .flush       (flush),
        .op          (fetch_op),
        .ras_top     (ras_top),
        .pred        (pred)
    );

endmodule

`default_nettype wire

// ==== tests/bp_ras_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module bp_ras_checker (
    input logic          clk,
    input logic          reset,
    input logic          fetch_valid,
    input bp_pkg::virt_t fetch_pc,
    input logic          flush,
    input bp_pkg::pred_t pred
);

    import bp_pkg::*;

    // number of assertion failures so far.
    int fail_count = 0;

    a_reset_clears_valid: assert property (@(posedge clk) reset |=> !pred.valid)
        else begin
            fail_count++;
            $error("pred.valid is high in the cycle after reset");
        end

    // one cycle from an accepted fetch to its prediction.
    a_valid_set: assert property (@(posedge clk) disable iff (reset)
        (fetch_valid && !flush) |=> pred.valid)
        else begin
            fail_count++;
            $error("no prediction one cycle after an accepted fetch");
        end

    a_valid_clear: assert property (@(posedge clk) disable iff (reset)
        !(fetch_valid && !flush) |=> !pred.valid)
        else begin
            fail_count++;
            $error("prediction without an accepted fetch in the cycle before");
        end

    a_seq_is_fallthrough: assert property (@(posedge clk) disable iff (reset)
        (pred.valid && pred.kind == kind_seq) |-> pred.pc == $past(fetch_pc) + virt_t'(4))
        else begin
            fail_count++;
            $error("sequential prediction is not pc+4");
        end

endmodule

bind bp_ras_top bp_ras_checker u_checker (
    .clk         (clk),
    .reset       (reset),
    .fetch_valid (fetch_valid),
    .fetch_pc    (fetch_pc),
    .flush       (flush),
    .pred        (pred)
);

`default_nettype wire

// ==== tests/tb_bp_ras.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_bp_ras;

    import bp_pkg::*;

    localparam int reset_cycles = 8;
    localparam int max_reset_wait = 20;
    localparam int max_lines = 200;

    logic  clk;
    logic  reset;
    logic  fetch_valid;
    virt_t fetch_pc;
    insn_u fetch_insn;
    logic  retire_valid;
    virt_t retire_pc;
    insn_u retire_insn;
    logic  flush;
    pred_t pred;

    int          fd;
    int          fields;
    int          cycles;
    int          line_no;
    int          exp_line;
    string       text;
    logic        fv;
    logic        rv;
    logic        fl;
    logic        ev;
    logic [31:0] fpc;
    logic [31:0] finsn;
    logic [31:0] rpc;
    logic [31:0] rinsn;
    logic [31:0] epc;
    logic [1:0]  ekind;
    pred_t       exp_pred;
    logic        have_exp;

    bp_ras_top i_bp_ras_top (
        .clk          (clk),
        .reset        (reset),
        .fetch_valid  (fetch_valid),
        .fetch_pc     (fetch_pc),
        .fetch_insn   (fetch_insn),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_insn  (retire_insn),
        .flush        (flush),
        .pred         (pred)
    );

    always #50 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    // pc is only meaningful when a prediction is expected.
    task automatic check_pred(input pred_t actual, input pred_t expected);
        if (actual.valid !== expected.valid) begin
            stop_on_error($sformatf("error: pred.valid is %h, expected %h (pattern %0d)",
                                    actual.valid, expected.valid, exp_line));
        end
        if (expected.valid && (actual.pc !== expected.pc)) begin
            stop_on_error($sformatf("error: pred.pc is %h, expected %h (pattern %0d)",
                                    actual.pc, expected.pc, exp_line));
        end
    endtask

    task automatic check_kind(input br_kind_e actual, input br_kind_e expected);
        if (actual !== expected) begin
            stop_on_error($sformatf("error: pred.kind is %h, expected %h (pattern %0d)",
                                    actual, expected, exp_line));
        end
    endtask

    task automatic check_expected();
        if (i_bp_ras_top.u_checker.fail_count != 0) begin
            stop_on_error("an assertion in the bound checker failed");
        end
        if (have_exp) begin
            check_pred(pred, exp_pred);
            if (exp_pred.valid) begin
                check_kind(pred.kind, exp_pred.kind);
            end
        end
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        fetch_valid  = 1'b0;
        fetch_pc     = '0;
        fetch_insn   = '0;
        retire_valid = 1'b0;
        retire_pc    = '0;
        retire_insn  = '0;
        flush        = 1'b0;
        have_exp     = 1'b0;
        line_no      = 0;
        exp_line     = 0;

        fd = $fopen("tests/bp_ras_patterns.txt", "r");
        if (fd == 0) begin
            stop_on_error("could not open the pattern file tests/bp_ras_patterns.txt");
        end

        cycles = 0;
        while (cycles < reset_cycles) begin
            @(posedge clk);
            cycles++;
        end
        reset <= 1'b0;
        cycles = 0;
        while (reset) begin
            if (cycles == max_reset_wait) begin
                stop_on_error("timed out waiting for reset to be released");
            end
            @(posedge clk);
            cycles++;
        end

        // one pattern per cycle, checked at the falling edge of the next cycle.
        cycles = 0;
        while (!$feof(fd)) begin
            if (cycles == max_lines) begin
                stop_on_error("timed out reading the pattern file");
            end
            cycles++;
            text = "";
            void'($fgets(text, fd));
            if (text.len() > 1 && text[0] != "#") begin
                fields = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h",
                                 fv, fpc, finsn, rv, rpc, rinsn, fl, ev, epc, ekind);
                if (fields != 10) begin
                    stop_on_error("a line of the pattern file does not hold ten fields");
                end
                line_no++;
                @(posedge clk);
                fetch_valid  <= fv;
                fetch_pc     <= fpc;
                fetch_insn   <= finsn;
                retire_valid <= rv;
                retire_pc    <= rpc;
                retire_insn  <= rinsn;
                flush        <= fl;
                @(negedge clk);
                check_expected();
                exp_pred.valid = ev;
                exp_pred.pc    = epc;
                exp_pred.kind  = br_kind_e'(ekind);
                exp_line       = line_no;
                have_exp       = 1'b1;
            end
        end
        $fclose(fd);

        @(posedge clk);
        fetch_valid  <= 1'b0;
        retire_valid <= 1'b0;
        flush        <= 1'b0;
        @(negedge clk);
        check_expected();

        if (line_no == 0) begin
            stop_on_error("the pattern file holds no patterns");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
source/bp_pkg.sv
source/ras.sv
source/ret_predecode.sv
source/next_pc_select.sv
source/bp_ras_top.sv
tests/bp_ras_checker.sv
tests/tb_bp_ras.sv

// ==== tests/bp_ras_patterns.txt ====
# fetch_valid fetch_pc fetch_insn retire_valid retire_pc retire_insn flush
# expected pred_valid pred_pc pred_kind (0 seq, 1 call, 2 ret, 3 coret), all hex
1 00001000 100000ef 0 00000000 00000000 0 1 00001100 1
1 00001100 000300e7 0 00000000 00000000 0 1 00001104 1
1 00002000 040000ef 0 00000000 00000000 0 1 00002040 1
1 00002040 00008067 0 00000000 00000000 0 1 00002004 2
1 00002008 00008067 0 00000000 00000000 0 1 00001104 2
1 00001108 00008067 0 00000000 00000000 0 1 00001004 2
1 00003000 200000ef 0 00000000 00000000 0 1 00003200 1
1 00003200 00000013 0 00000000 00000000 0 1 00003204 0
1 00003204 00030067 0 00000000 00000000 0 1 00003208 0
0 00000000 00000000 0 00000000 00000000 0 0 00000000 0
1 00003208 00008067 0 00000000 00000000 0 1 00003004 2
1 00004000 100000ef 0 00000000 00000000 0 1 00004100 1
1 00004100 000080e7 0 00000000 00000000 0 1 00004004 3
1 00004004 00008067 0 00000000 00000000 0 1 00004104 2
1 00005000 040000ef 0 00000000 00000000 0 1 00005040 1
1 00005040 040000ef 0 00000000 00000000 0 1 00005080 1
1 00005080 040000ef 0 00000000 00000000 0 1 000050c0 1
1 000050c0 040000ef 0 00000000 00000000 0 1 00005100 1
1 00005100 040000ef 0 00000000 00000000 0 1 00005140 1
1 00005140 040000ef 0 00000000 00000000 0 1 00005180 1
1 00005180 040000ef 0 00000000 00000000 0 1 000051c0 1
1 000051c0 040000ef 0 00000000 00000000 0 1 00005200 1
1 00005200 040000ef 0 00000000 00000000 0 1 00005240 1
1 00006000 00008067 0 00000000 00000000 0 1 00005204 2
1 00006004 00008067 0 00000000 00000000 0 1 000051c4 2
1 00006008 00008067 0 00000000 00000000 0 1 00005184 2
1 0000600c 00008067 0 00000000 00000000 0 1 00005144 2
1 00006010 00008067 0 00000000 00000000 0 1 00005104 2
1 00006014 00008067 0 00000000 00000000 0 1 000050c4 2
1 00006018 00008067 0 00000000 00000000 0 1 00005084 2
1 0000601c 00008067 0 00000000 00000000 0 1 00005044 2
1 00006020 00008067 0 00000000 00000000 0 1 00006024 2
1 00007000 100000ef 1 00007000 100000ef 0 1 00007100 1
1 00007100 040000ef 0 00000000 00000000 0 1 00007140 1
1 00007140 00008067 0 00000000 00000000 0 1 00007104 2
1 00007108 200000ef 0 00000000 00000000 0 1 00007308 1
1 00007308 00008067 1 00007100 040000ef 1 0 00000000 0
1 00008000 00008067 0 00000000 00000000 0 1 00007104 2
1 00008004 00008067 0 00000000 00000000 0 1 00007004 2
0 00000000 00000000 0 00000000 00000000 0 0 00000000 0
